// File: source/execPkg.sv
package execPkg;

  // Widths shared by the execute stage
  localparam int aluCtrlWidth = 6;
  localparam int flagsWidth = 5;
  localparam int regAddrWidth = 4;

  // Flag vector layout, Q on top
  localparam int flagQ = 4;
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // ALU control codes
  localparam logic [aluCtrlWidth-1:0] opAdd    = 6'b100000;
  localparam logic [aluCtrlWidth-1:0] opAdc    = 6'b100001;
  localparam logic [aluCtrlWidth-1:0] opQadd   = 6'b100010;
  localparam logic [aluCtrlWidth-1:0] opSub    = 6'b100011;
  localparam logic [aluCtrlWidth-1:0] opSbc    = 6'b100100;
  localparam logic [aluCtrlWidth-1:0] opRsb    = 6'b100101;
  localparam logic [aluCtrlWidth-1:0] opQsub   = 6'b100110;
  localparam logic [aluCtrlWidth-1:0] opMul    = 6'b100111;
  localparam logic [aluCtrlWidth-1:0] opMla    = 6'b101000;
  localparam logic [aluCtrlWidth-1:0] opMls    = 6'b101001;
  localparam logic [aluCtrlWidth-1:0] opUmull  = 6'b101010;
  localparam logic [aluCtrlWidth-1:0] opUmlal  = 6'b101011;
  localparam logic [aluCtrlWidth-1:0] opSmull  = 6'b101100;
  localparam logic [aluCtrlWidth-1:0] opSmlal  = 6'b101101;
  localparam logic [aluCtrlWidth-1:0] opUdiv   = 6'b101110;
  localparam logic [aluCtrlWidth-1:0] opSdiv   = 6'b101111;
  localparam logic [aluCtrlWidth-1:0] opAnd    = 6'b110000;
  localparam logic [aluCtrlWidth-1:0] opBic    = 6'b110001;
  localparam logic [aluCtrlWidth-1:0] opOrr    = 6'b110010;
  localparam logic [aluCtrlWidth-1:0] opOrn    = 6'b110011;
  localparam logic [aluCtrlWidth-1:0] opEor    = 6'b110100;
  localparam logic [aluCtrlWidth-1:0] opCmn    = 6'b110101;
  localparam logic [aluCtrlWidth-1:0] opTst    = 6'b110110;
  localparam logic [aluCtrlWidth-1:0] opTeq    = 6'b110111;
  localparam logic [aluCtrlWidth-1:0] opCmp    = 6'b111000;
  localparam logic [aluCtrlWidth-1:0] opMov    = 6'b111001;
  localparam logic [aluCtrlWidth-1:0] opRshift = 6'b111010;
  localparam logic [aluCtrlWidth-1:0] opAshift = 6'b111011;
  localparam logic [aluCtrlWidth-1:0] opLshift = 6'b111100;
  localparam logic [aluCtrlWidth-1:0] opRor    = 6'b111101;
  localparam logic [aluCtrlWidth-1:0] opRrx    = 6'b111110;
  localparam logic [aluCtrlWidth-1:0] opEon    = 6'b111111;
  localparam logic [aluCtrlWidth-1:0] opB      = 6'b010000;
  localparam logic [aluCtrlWidth-1:0] opCbz    = 6'b010010;
  localparam logic [aluCtrlWidth-1:0] opCbnz   = 6'b010011;

  // Op classes
  function automatic logic isLongMul(input logic [aluCtrlWidth-1:0] op);
    return op inside {opUmull, opUmlal, opSmull, opSmlal};
  endfunction

  // Long ops that read rdHi as accumulator high word
  function automatic logic isAccLong(input logic [aluCtrlWidth-1:0] op);
    return op inside {opUmlal, opSmlal};
  endfunction

  function automatic logic isFlagOnly(input logic [aluCtrlWidth-1:0] op);
    return op inside {opCmn, opCmp, opTst, opTeq};
  endfunction

  function automatic logic isBranch(input logic [aluCtrlWidth-1:0] op);
    return op inside {opB, opCbz, opCbnz};
  endfunction

endpackage

// File: source/alu.sv
`timescale 1ns/100ps

module alu import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0]    a,
  input  logic [dataWidth-1:0]    b,
  input  logic [2*dataWidth-1:0]  mulOrigin,
  input  logic [aluCtrlWidth-1:0] aluControl,
  input  logic                    carryIn,
  input  logic [dataWidth-1:0]    cbzValue,
  output logic [2*dataWidth-1:0]  result,
  output logic [flagsWidth-1:0]   aluFlags,
  output logic [flagsWidth-1:0]   flagsUpdate
);

  localparam int shW = $clog2(dataWidth);
  localparam logic [dataWidth-1:0] satMax = {1'b0, {(dataWidth-1){1'b1}}};
  localparam logic [dataWidth-1:0] satMin = {1'b1, {(dataWidth-1){1'b0}}};

  logic [shW-1:0]         shAmt;
  logic [dataWidth-1:0]   addX;
  logic [dataWidth-1:0]   addY;
  logic                   addCin;
  logic [dataWidth:0]     addSum;
  logic                   addOvf;
  logic [2*dataWidth-1:0] prodU;
  logic [2*dataWidth-1:0] prodS;
  logic [dataWidth-1:0]   uQuot;
  logic signed [dataWidth-1:0] sQuot;
  logic [dataWidth:0]     lslExt;
  logic [dataWidth:0]     lsrExt;
  logic [dataWidth:0]     asrExt;
  logic [2*dataWidth-1:0] rorExt;
  logic [dataWidth-1:0]   target;
  logic [dataWidth-1:0]   lo;

  assign shAmt = b[shW-1:0];

  // Shared adder, subtracts are x + ~y + cin
  always_comb begin
    addX = a;
    addY = b;
    addCin = 1'b0;
    case (aluControl)
      opAdc: addCin = carryIn;
      opSub, opCmp, opQsub: begin
        addY = ~b;
        addCin = 1'b1;
      end
      opSbc: begin
        addY = ~b;
        addCin = carryIn;
      end
      opRsb: begin
        addX = b;
        addY = ~a;
        addCin = 1'b1;
      end
      default: ;
    endcase
  end

  assign addSum = {1'b0, addX} + {1'b0, addY} + {{dataWidth{1'b0}}, addCin};
  assign addOvf = (addX[dataWidth-1] == addY[dataWidth-1]) &&
                  (addSum[dataWidth-1] != addX[dataWidth-1]);

  // Products at full width; sign extension gives the signed form
  assign prodU = {{dataWidth{1'b0}}, a} * {{dataWidth{1'b0}}, b};
  assign prodS = {{dataWidth{a[dataWidth-1]}}, a} * {{dataWidth{b[dataWidth-1]}}, b};

  assign uQuot = a / b;
  assign sQuot = $signed(a) / $signed(b);

  // Extra bit catches the last bit shifted out
  assign lslExt = {1'b0, a} << shAmt;
  assign lsrExt = {a, 1'b0} >> shAmt;
  assign asrExt = $signed({a, 1'b0}) >>> shAmt;
  assign rorExt = {a, a} >> shAmt;

  assign target = a + (b << 2);

  always_comb begin
    lo = '0;
    result = '0;
    case (aluControl)
      opAdd, opAdc, opSub, opSbc, opRsb, opCmn, opCmp: lo = addSum[dataWidth-1:0];
      opQadd, opQsub: begin
        // On overflow the true sign is that of the first operand
        if (addOvf) begin
          lo = addX[dataWidth-1] ? satMin : satMax;
        end else begin
          lo = addSum[dataWidth-1:0];
        end
      end
      opMul: lo = prodU[dataWidth-1:0];
      opMla: lo = mulOrigin[dataWidth-1:0] + prodU[dataWidth-1:0];
      opMls: lo = mulOrigin[dataWidth-1:0] - prodU[dataWidth-1:0];
      opUmull: result = prodU;
      opUmlal: result = prodU + mulOrigin;
      opSmull: result = prodS;
      opSmlal: result = prodS + mulOrigin;
      opUdiv: lo = (b != '0) ? uQuot : '0;
      opSdiv: lo = (b != '0) ? sQuot : '0;
      opAnd, opTst: lo = a & b;
      opBic: lo = a & ~b;
      opOrr: lo = a | b;
      opOrn: lo = a | ~b;
      opEor, opTeq: lo = a ^ b;
      opEon: lo = a ^ ~b;
      opMov: lo = b;
      opLshift: lo = lslExt[dataWidth-1:0];
      opRshift: lo = lsrExt[dataWidth:1];
      opAshift: lo = asrExt[dataWidth:1];
      opRor: lo = rorExt[dataWidth-1:0];
      opRrx: lo = {carryIn, a[dataWidth-1:1]};
      opB: lo = target;
      opCbz: lo = (cbzValue == '0) ? target : a;
      opCbnz: lo = (cbzValue != '0) ? target : a;
      default: lo = '0;
    endcase
    if (!isLongMul(aluControl)) begin
      result = {{dataWidth{1'b0}}, lo};
    end
  end

  // Flags plus a mask of which ones this op may change
  always_comb begin
    aluFlags = '0;
    flagsUpdate = '0;
    flagsUpdate[flagN] = 1'b1;
    flagsUpdate[flagZ] = 1'b1;
    if (isLongMul(aluControl)) begin
      aluFlags[flagN] = result[2*dataWidth-1];
      aluFlags[flagZ] = (result == '0);
    end else begin
      aluFlags[flagN] = lo[dataWidth-1];
      aluFlags[flagZ] = (lo == '0);
    end
    case (aluControl)
      opAdd, opAdc, opCmn, opSub, opSbc, opRsb, opCmp: begin
        aluFlags[flagC] = addSum[dataWidth];
        aluFlags[flagV] = addOvf;
        flagsUpdate[flagC] = 1'b1;
        flagsUpdate[flagV] = 1'b1;
      end
      opQadd, opQsub: begin
        aluFlags[flagQ] = addOvf;
        flagsUpdate[flagQ] = 1'b1;
      end
      opLshift: begin
        aluFlags[flagC] = lslExt[dataWidth];
        flagsUpdate[flagC] = (shAmt != '0);
      end
      opRshift: begin
        aluFlags[flagC] = lsrExt[0];
        flagsUpdate[flagC] = (shAmt != '0);
      end
      opAshift: begin
        aluFlags[flagC] = asrExt[0];
        flagsUpdate[flagC] = (shAmt != '0);
      end
      opRrx: begin
        aluFlags[flagC] = a[0];
        flagsUpdate[flagC] = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: source/regFile.sv
`timescale 1ns/100ps

module regFile import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [regAddrWidth-1:0] raddrA,
  input  logic [regAddrWidth-1:0] raddrB,
  input  logic [regAddrWidth-1:0] raddrC,
  input  logic [regAddrWidth-1:0] raddrD,
  input  logic                    wenLo,
  input  logic [regAddrWidth-1:0] waddrLo,
  input  logic [dataWidth-1:0]    wdataLo,
  input  logic                    wenHi,
  input  logic [regAddrWidth-1:0] waddrHi,
  input  logic [dataWidth-1:0]    wdataHi,
  output logic [dataWidth-1:0]    rdataA,
  output logic [dataWidth-1:0]    rdataB,
  output logic [dataWidth-1:0]    rdataC,
  output logic [dataWidth-1:0]    rdataD
);

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // High-word port is written last so it wins a shared address
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wenLo) begin
        regs[waddrLo] <= wdataLo;
      end
      if (wenHi) begin
        regs[waddrHi] <= wdataHi;
      end
    end
  end

  // Asynchronous reads
  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];
  assign rdataC = regs[raddrC];
  assign rdataD = regs[raddrD];

endmodule

// File: source/operandSelect.sv
`timescale 1ns/100ps

module operandSelect import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [aluCtrlWidth-1:0] aluControl,
  input  logic                    useImm,
  input  logic [dataWidth-1:0]    imm,
  input  logic [regAddrWidth-1:0] rn,
  input  logic [regAddrWidth-1:0] rm,
  input  logic [regAddrWidth-1:0] ra,
  input  logic [regAddrWidth-1:0] rd,
  input  logic [regAddrWidth-1:0] rdHi,
  input  logic [dataWidth-1:0]    rdataA,
  input  logic [dataWidth-1:0]    rdataB,
  input  logic [dataWidth-1:0]    rdataC,
  input  logic [dataWidth-1:0]    rdataD,
  input  logic                    retWenLo,
  input  logic [regAddrWidth-1:0] retAddrLo,
  input  logic [dataWidth-1:0]    retDataLo,
  input  logic                    retWenHi,
  input  logic [regAddrWidth-1:0] retAddrHi,
  input  logic [dataWidth-1:0]    retDataHi,
  output logic [regAddrWidth-1:0] raddrD,
  output logic [dataWidth-1:0]    opA,
  output logic [dataWidth-1:0]    opB,
  output logic [2*dataWidth-1:0]  mulOrigin,
  output logic [dataWidth-1:0]    cbzValue
);

  logic                 accLong;
  logic [dataWidth-1:0] valA;
  logic [dataWidth-1:0] valB;
  logic [dataWidth-1:0] valC;
  logic [dataWidth-1:0] valD;

  // Retire register bypass, high port takes priority like the file
  function automatic logic [dataWidth-1:0] forward(
    input logic [regAddrWidth-1:0] addr,
    input logic [dataWidth-1:0]    fileVal
  );
    logic [dataWidth-1:0] val;
    val = fileVal;
    if (retWenLo && (retAddrLo == addr)) begin
      val = retDataLo;
    end
    if (retWenHi && (retAddrHi == addr)) begin
      val = retDataHi;
    end
    return val;
  endfunction

  // Port D serves rdHi for accumulate longs, rd otherwise
  assign accLong = isAccLong(aluControl);
  assign raddrD = accLong ? rdHi : rd;

  always_comb begin
    valA = forward(rn, rdataA);
    valB = forward(rm, rdataB);
    valC = forward(ra, rdataC);
    valD = forward(raddrD, rdataD);
  end

  assign opA = valA;
  assign opB = useImm ? imm : valB;
  assign mulOrigin = {(accLong ? valD : {dataWidth{1'b0}}), valC};
  assign cbzValue = valD;

endmodule

// File: source/retireStage.sv
`timescale 1ns/100ps

module retireStage import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    issue,
  input  logic [aluCtrlWidth-1:0] aluControl,
  input  logic [regAddrWidth-1:0] rd,
  input  logic [regAddrWidth-1:0] rdHi,
  input  logic                    setFlags,
  input  logic [2*dataWidth-1:0]  result,
  input  logic [flagsWidth-1:0]   aluFlags,
  input  logic [flagsWidth-1:0]   flagsUpdate,
  output logic                    wenLo,
  output logic [regAddrWidth-1:0] waddrLo,
  output logic [dataWidth-1:0]    wdataLo,
  output logic                    wenHi,
  output logic [regAddrWidth-1:0] waddrHi,
  output logic [dataWidth-1:0]    wdataHi,
  output logic                    carryOut,
  output logic                    retireValid,
  output logic [2*dataWidth-1:0]  retireResult,
  output logic [flagsWidth-1:0]   retireFlags
);

  logic                    validQ;
  logic                    wenLoQ;
  logic                    wenHiQ;
  logic                    setFlagsQ;
  logic [2*dataWidth-1:0]  resultQ;
  logic [flagsWidth-1:0]   flagsQ;
  logic [flagsWidth-1:0]   updQ;
  logic [regAddrWidth-1:0] rdQ;
  logic [regAddrWidth-1:0] rdHiQ;
  logic [flagsWidth-1:0]   storedFlags;
  logic [flagsWidth-1:0]   flagsNext;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
      wenLoQ <= 1'b0;
      wenHiQ <= 1'b0;
      setFlagsQ <= 1'b0;
    end else begin
      validQ <= issue;
      wenLoQ <= issue && !isFlagOnly(aluControl) && !isBranch(aluControl);
      wenHiQ <= issue && isLongMul(aluControl);
      setFlagsQ <= issue && setFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      resultQ <= result;
      flagsQ <= aluFlags;
      updQ <= flagsUpdate;
      rdQ <= rd;
      rdHiQ <= rdHi;
    end
  end

  // Flags as they will be after this retire
  always_comb begin
    flagsNext = storedFlags;
    if (setFlagsQ) begin
      for (int i = 0; i < flagsWidth; i++) begin
        if (updQ[i]) begin
          flagsNext[i] = flagsQ[i];
        end
      end
    end
    // Q is sticky and ignores setFlags
    flagsNext[flagQ] = storedFlags[flagQ] | (validQ & updQ[flagQ] & flagsQ[flagQ]);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      storedFlags <= '0;
    end else begin
      storedFlags <= flagsNext;
    end
  end

  assign wenLo = wenLoQ;
  assign waddrLo = rdQ;
  assign wdataLo = resultQ[dataWidth-1:0];
  assign wenHi = wenHiQ;
  assign waddrHi = rdHiQ;
  assign wdataHi = resultQ[2*dataWidth-1:dataWidth];

  // Carry for an issue in the retire cycle
  assign carryOut = flagsNext[flagC];

  assign retireValid = validQ;
  assign retireResult = resultQ;
  assign retireFlags = flagsNext;

endmodule

// File: source/execTop.sv
`timescale 1ns/100ps

module execTop import execPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    issue,
  input  logic [aluCtrlWidth-1:0] aluControl,
  input  logic [regAddrWidth-1:0] rn,
  input  logic [regAddrWidth-1:0] rm,
  input  logic [regAddrWidth-1:0] ra,
  input  logic [regAddrWidth-1:0] rd,
  input  logic [regAddrWidth-1:0] rdHi,
  input  logic                    useImm,
  input  logic [dataWidth-1:0]    imm,
  input  logic                    setFlags,
  output logic                    retireValid,
  output logic [2*dataWidth-1:0]  retireResult,
  output logic [flagsWidth-1:0]   retireFlags
);

  logic [dataWidth-1:0]    rdataA;
  logic [dataWidth-1:0]    rdataB;
  logic [dataWidth-1:0]    rdataC;
  logic [dataWidth-1:0]    rdataD;
  logic [regAddrWidth-1:0] raddrD;
  logic [dataWidth-1:0]    opA;
  logic [dataWidth-1:0]    opB;
  logic [2*dataWidth-1:0]  mulOrigin;
  logic [dataWidth-1:0]    cbzValue;
  logic [2*dataWidth-1:0]  result;
  logic [flagsWidth-1:0]   aluFlags;
  logic [flagsWidth-1:0]   flagsUpdate;
  logic                    wenLo;
  logic [regAddrWidth-1:0] waddrLo;
  logic [dataWidth-1:0]    wdataLo;
  logic                    wenHi;
  logic [regAddrWidth-1:0] waddrHi;
  logic [dataWidth-1:0]    wdataHi;
  logic                    storedCarry;

  regFile #(.dataWidth(dataWidth)) regs (
    .clk(clk), .rstN(rstN),
    .raddrA(rn), .raddrB(rm), .raddrC(ra), .raddrD(raddrD),
    .wenLo(wenLo), .waddrLo(waddrLo), .wdataLo(wdataLo),
    .wenHi(wenHi), .waddrHi(waddrHi), .wdataHi(wdataHi),
    .rdataA(rdataA), .rdataB(rdataB), .rdataC(rdataC), .rdataD(rdataD)
  );

  // Bypass comes straight from the retire write ports
  operandSelect #(.dataWidth(dataWidth)) opSel (
    .aluControl(aluControl), .useImm(useImm), .imm(imm),
    .rn(rn), .rm(rm), .ra(ra), .rd(rd), .rdHi(rdHi),
    .rdataA(rdataA), .rdataB(rdataB), .rdataC(rdataC), .rdataD(rdataD),
    .retWenLo(wenLo), .retAddrLo(waddrLo), .retDataLo(wdataLo),
    .retWenHi(wenHi), .retAddrHi(waddrHi), .retDataHi(wdataHi),
    .raddrD(raddrD), .opA(opA), .opB(opB), .mulOrigin(mulOrigin), .cbzValue(cbzValue)
  );

  alu #(.dataWidth(dataWidth)) aluInst (
    .a(opA), .b(opB), .mulOrigin(mulOrigin), .aluControl(aluControl),
    .carryIn(storedCarry), .cbzValue(cbzValue),
    .result(result), .aluFlags(aluFlags), .flagsUpdate(flagsUpdate)
  );

  retireStage #(.dataWidth(dataWidth)) retire (
    .clk(clk), .rstN(rstN), .issue(issue), .aluControl(aluControl),
    .rd(rd), .rdHi(rdHi), .setFlags(setFlags),
    .result(result), .aluFlags(aluFlags), .flagsUpdate(flagsUpdate),
    .wenLo(wenLo), .waddrLo(waddrLo), .wdataLo(wdataLo),
    .wenHi(wenHi), .waddrHi(waddrHi), .wdataHi(wdataHi),
    .carryOut(storedCarry), .retireValid(retireValid),
    .retireResult(retireResult), .retireFlags(retireFlags)
  );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
  parameter int periodNs = 100
) (
  output logic clk
);

  // Free-running clock, low in the first half period
  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2);
      clk = ~clk;
    end
  end

endmodule

// File: sim/execTopTb.sv
`timescale 1ns/100ps

module execTopTb import execPkg::*; ();

  localparam int dataWidth = 32;
  localparam int clkPeriod = 100;
  localparam int resetCycles = 10;
  localparam int driveDelay = 10;
  localparam int numRandom = 64;
  localparam int numMulRounds = 12;
  localparam int numDivRandom = 10;
  localparam int numChain = 24;
  // Fixed terms cover loads, carry set and the Q, division, RRX, branch and readback runs
  localparam int totalIssues = 16 + numRandom + 7 + 3 * numMulRounds + 8 + numDivRandom
                               + 1 + 4 * 32 + 8 + numChain + 7 + 16;
  localparam longint sMax = 64'sd2147483647;
  localparam longint sMin = -64'sd2147483648;

  logic                    clk;
  logic                    rstN;
  logic                    issue;
  logic [aluCtrlWidth-1:0] aluControl;
  logic [regAddrWidth-1:0] rn;
  logic [regAddrWidth-1:0] rm;
  logic [regAddrWidth-1:0] ra;
  logic [regAddrWidth-1:0] rd;
  logic [regAddrWidth-1:0] rdHi;
  logic                    useImm;
  logic [dataWidth-1:0]    imm;
  logic                    setFlags;
  logic                    retireValid;
  logic [2*dataWidth-1:0]  retireResult;
  logic [flagsWidth-1:0]   retireFlags;

  // Reference model state
  logic [dataWidth-1:0]    model [16];
  logic [flagsWidth-1:0]   mFlags;
  logic [31:0]             lfsrState;
  logic [2*dataWidth-1:0]  pendResult;
  logic [flagsWidth-1:0]   pendFlags;
  logic [2*dataWidth-1:0]  expResult;
  logic [flagsWidth-1:0]   expFlags;
  logic                    expValid;

  logic [aluCtrlWidth-1:0] op;
  logic [regAddrWidth-1:0] d;
  logic [regAddrWidth-1:0] n;
  logic [regAddrWidth-1:0] m;
  logic [regAddrWidth-1:0] x;
  logic [regAddrWidth-1:0] h;
  logic [regAddrWidth-1:0] lastD;
  logic [dataWidth-1:0]    val;
  logic                    immBit;
  logic                    sfBit;

  clockGen #(.periodNs(clkPeriod)) clkGen (.clk(clk));

  execTop #(.dataWidth(dataWidth)) uut (
    .clk(clk), .rstN(rstN), .issue(issue), .aluControl(aluControl),
    .rn(rn), .rm(rm), .ra(ra), .rd(rd), .rdHi(rdHi),
    .useImm(useImm), .imm(imm), .setFlags(setFlags),
    .retireValid(retireValid), .retireResult(retireResult), .retireFlags(retireFlags)
  );

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic logic [aluCtrlWidth-1:0] pickBasic(input logic [3:0] k);
    case (k)
      4'd0: return opAdd;
      4'd1: return opAdc;
      4'd2: return opSub;
      4'd3: return opSbc;
      4'd4: return opRsb;
      4'd5: return opAnd;
      4'd6: return opBic;
      4'd7: return opOrr;
      4'd8: return opOrn;
      4'd9: return opEor;
      4'd10: return opEon;
      4'd11: return opMov;
      4'd12: return opCmn;
      4'd13: return opCmp;
      4'd14: return opTst;
      default: return opTeq;
    endcase
  endfunction

  function automatic logic [aluCtrlWidth-1:0] pickMul(input logic [2:0] k);
    case (k)
      3'd0: return opMul;
      3'd1: return opMla;
      3'd2: return opMls;
      3'd3: return opUmull;
      3'd4: return opUmlal;
      3'd5: return opSmull;
      default: return opSmlal;
    endcase
  endfunction

  // Expected result and flags of one operation
  function automatic void refExec(
    input  logic [aluCtrlWidth-1:0] opc,
    input  logic [dataWidth-1:0]    a,
    input  logic [dataWidth-1:0]    b,
    input  logic [dataWidth-1:0]    accLo,
    input  logic [dataWidth-1:0]    accHi,
    input  logic [dataWidth-1:0]    rdVal,
    input  logic [flagsWidth-1:0]   fIn,
    input  logic                    sf,
    output logic [2*dataWidth-1:0]  res,
    output logic [flagsWidth-1:0]   fOut
  );
    logic [31:0] lo;
    logic [31:0] target;
    logic [63:0] full;
    logic [32:0] wide;
    logic        cin;
    logic        cy;
    logic        c;
    logic        v;
    logic        sat;
    logic        isLong;
    longint      sA;
    longint      sB;
    longint      sR;
    int          amt;
    cin = fIn[flagC];
    c = cin;
    v = fIn[flagV];
    sat = 1'b0;
    sA = longint'($signed(a));
    sB = longint'($signed(b));
    amt = int'(b[4:0]);
    target = a + (b << 2);
    isLong = opc inside {opUmull, opUmlal, opSmull, opSmlal};
    lo = '0;
    full = '0;
    case (opc)
      opAdd, opAdc, opCmn: begin
        cy = (opc == opAdc) ? cin : 1'b0;
        wide = {1'b0, a} + {1'b0, b} + 33'(cy);
        lo = wide[31:0];
        c = wide[32];
        sR = sA + sB + longint'(cy);
        v = (sR > sMax) || (sR < sMin);
      end
      opSub, opSbc, opCmp: begin
        // Borrow is the inverted stored carry for SBC
        cy = (opc == opSbc) ? !cin : 1'b0;
        lo = a - b - 32'(cy);
        c = {1'b0, a} >= ({1'b0, b} + 33'(cy));
        sR = sA - sB - longint'(cy);
        v = (sR > sMax) || (sR < sMin);
      end
      opRsb: begin
        lo = b - a;
        c = b >= a;
        sR = sB - sA;
        v = (sR > sMax) || (sR < sMin);
      end
      opQadd, opQsub: begin
        sR = (opc == opQadd) ? sA + sB : sA - sB;
        sat = (sR > sMax) || (sR < sMin);
        lo = (sR > sMax) ? 32'h7FFFFFFF : (sR < sMin) ? 32'h80000000 : 32'(sR);
      end
      opMul: lo = a * b;
      opMla: lo = accLo + a * b;
      opMls: lo = accLo - a * b;
      opUmull: full = {32'b0, a} * {32'b0, b};
      opUmlal: full = {32'b0, a} * {32'b0, b} + {accHi, accLo};
      opSmull: full = 64'(sA * sB);
      opSmlal: full = 64'(sA * sB) + {accHi, accLo};
      opUdiv: lo = (b == '0) ? '0 : a / b;
      opSdiv: lo = (b == '0) ? '0 : 32'(sA / sB);
      opAnd, opTst: lo = a & b;
      opBic: lo = a & ~b;
      opOrr: lo = a | b;
      opOrn: lo = a | ~b;
      opEor, opTeq: lo = a ^ b;
      opEon: lo = ~(a ^ b);
      opMov: lo = b;
      opLshift: begin
        lo = a << amt;
        if (amt != 0) c = a[32 - amt];
      end
      opRshift: begin
        lo = a >> amt;
        if (amt != 0) c = a[amt - 1];
      end
      opAshift: begin
        lo = 32'(sA >>> amt);
        if (amt != 0) c = a[amt - 1];
      end
      opRor: lo = (a >> amt) | (a << (32 - amt));
      opRrx: begin
        lo = {cin, a[31:1]};
        c = a[0];
      end
      opB: lo = target;
      opCbz: lo = (rdVal == '0) ? target : a;
      opCbnz: lo = (rdVal != '0) ? target : a;
      default: lo = '0;
    endcase
    if (!isLong) begin
      full = {32'b0, lo};
    end
    res = full;
    fOut = fIn;
    if (sf) begin
      fOut[flagN] = isLong ? full[63] : lo[31];
      fOut[flagZ] = isLong ? (full == '0) : (lo == '0);
      fOut[flagC] = c;
      fOut[flagV] = v;
    end
    fOut[flagQ] = fIn[flagQ] | sat;
  endfunction

  // Update the model, then present the issue for one cycle
  task automatic issueOp(
    input logic [aluCtrlWidth-1:0] opc,
    input logic [regAddrWidth-1:0] dst,
    input logic [regAddrWidth-1:0] srcN,
    input logic [regAddrWidth-1:0] srcM,
    input logic [regAddrWidth-1:0] srcA,
    input logic [regAddrWidth-1:0] dstHi,
    input logic                    immSel,
    input logic [dataWidth-1:0]    immVal,
    input logic                    sf
  );
    logic [dataWidth-1:0]   bVal;
    logic [2*dataWidth-1:0] res;
    logic [flagsWidth-1:0]  fNew;
    bVal = immSel ? immVal : model[srcM];
    refExec(opc, model[srcN], bVal, model[srcA], model[dstHi], model[dst], mFlags, sf,
            res, fNew);
    if (!(opc inside {opCmn, opCmp, opTst, opTeq, opB, opCbz, opCbnz})) begin
      model[dst] = res[31:0];
    end
    if (opc inside {opUmull, opUmlal, opSmull, opSmlal}) begin
      model[dstHi] = res[63:32];
    end
    mFlags = fNew;
    pendResult = res;
    pendFlags = fNew;
    issue = 1'b1;
    aluControl = opc;
    rn = srcN;
    rm = srcM;
    ra = srcA;
    rd = dst;
    rdHi = dstHi;
    useImm = immSel;
    imm = immVal;
    setFlags = sf;
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic loadReg(input logic [regAddrWidth-1:0] dst, input logic [31:0] value);
    issueOp(opMov, dst, 4'd0, 4'd0, 4'd0, 4'd0, 1'b1, value, 1'b0);
  endtask

  // Expected values line up with the retire cycle
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      expValid <= 1'b0;
      expResult <= '0;
      expFlags <= '0;
    end else begin
      expValid <= issue;
      expResult <= pendResult;
      expFlags <= pendFlags;
    end
  end

  validCheck: assert property (@(posedge clk) disable iff (!rstN) retireValid == expValid)
    else abortRun($sformatf("retireValid was %0b at %0t while %0b was expected",
                            $sampled(retireValid), $time, $sampled(expValid)));

  resultCheck: assert property (@(posedge clk) disable iff (!rstN)
                                retireValid |-> retireResult == expResult)
    else abortRun($sformatf("mismatch at %0t: result %h, expected %h",
                            $time, $sampled(retireResult), $sampled(expResult)));

  flagsCheck: assert property (@(posedge clk) disable iff (!rstN)
                               retireValid |-> retireFlags == expFlags)
    else abortRun($sformatf("mismatch at %0t: flags QNZCV %b, expected %b",
                            $time, $sampled(retireFlags), $sampled(expFlags)));

  initial begin
    #((2 * totalIssues + resetCycles) * clkPeriod);
    abortRun("watchdog expired before the stimulus finished");
  end

  initial begin
    lfsrState = 32'h35660242;
    rstN = 1'b0;
    issue = 1'b0;
    aluControl = '0;
    rn = '0;
    rm = '0;
    ra = '0;
    rd = '0;
    rdHi = '0;
    useImm = 1'b0;
    imm = '0;
    setFlags = 1'b0;
    mFlags = '0;
    pendResult = '0;
    pendFlags = '0;
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;

    for (int i = 0; i < 16; i++) begin
      loadReg(4'(i), randBits(32));
    end

    // Arithmetic, logic and compares
    for (int i = 0; i < numRandom; i++) begin
      op = pickBasic(4'(i));
      d = 4'(randBits(4));
      n = 4'(randBits(4));
      m = 4'(randBits(4));
      immBit = 1'(randBits(1));
      val = randBits(32);
      sfBit = 1'(randBits(1));
      issueOp(op, d, n, m, 4'd0, 4'd0, immBit, val, sfBit);
    end

    // Saturating ops and later ops that keep Q
    loadReg(4'd1, 32'h7FFFFFF0);
    loadReg(4'd2, 32'h00000020);
    issueOp(opQadd, 4'd3, 4'd1, 4'd2, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    loadReg(4'd4, 32'h80000010);
    issueOp(opQsub, 4'd5, 4'd4, 4'd2, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opQadd, 4'd6, 4'd2, 4'd2, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opAdd, 4'd7, 4'd2, 4'd2, 4'd0, 4'd0, 1'b0, '0, 1'b1);

    // Multiplies with both halves read back
    for (int i = 0; i < numMulRounds; i++) begin
      op = pickMul(3'(i % 7));
      d = 4'(randBits(4));
      h = d + 4'd1 + 4'(randBits(3));
      n = 4'(randBits(4));
      m = 4'(randBits(4));
      x = 4'(randBits(4));
      issueOp(op, d, n, m, x, h, 1'b0, '0, 1'b1);
      issueOp(opMov, d, 4'd0, d, 4'd0, 4'd0, 1'b0, '0, 1'b0);
      issueOp(opMov, h, 4'd0, h, 4'd0, 4'd0, 1'b0, '0, 1'b0);
    end

    loadReg(4'd4, 32'hFFFFFF9C);
    loadReg(4'd5, 32'd7);
    loadReg(4'd6, 32'd0);
    issueOp(opSdiv, 4'd7, 4'd4, 4'd5, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opUdiv, 4'd8, 4'd4, 4'd5, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opSdiv, 4'd9, 4'd4, 4'd6, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opUdiv, 4'd10, 4'd4, 4'd6, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    issueOp(opSdiv, 4'd11, 4'd4, 4'd0, 4'd0, 4'd0, 1'b1, 32'hFFFFFFFD, 1'b1);
    // Small divisors so zero shows up now and then
    for (int i = 0; i < numDivRandom; i++) begin
      op = randBits(1) ? opSdiv : opUdiv;
      d = 4'(randBits(4));
      n = 4'(randBits(4));
      val = randBits(8);
      issueOp(op, d, n, 4'd0, 4'd0, 4'd0, 1'b1, val, 1'b1);
    end

    // Stored C set so a zero amount shows C kept
    issueOp(opCmp, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    for (int amt = 0; amt < 32; amt++) begin
      for (int k = 0; k < 4; k++) begin
        op = (k == 0) ? opLshift : (k == 1) ? opRshift : (k == 2) ? opAshift : opRor;
        d = 4'(randBits(4));
        n = 4'(randBits(4));
        issueOp(op, d, n, 4'd0, 4'd0, 4'd0, 1'b1, 32'(amt), 1'b1);
      end
    end
    for (int i = 0; i < 8; i++) begin
      d = 4'(randBits(4));
      n = 4'(randBits(4));
      issueOp(opRrx, d, n, 4'd0, 4'd0, 4'd0, 1'b0, '0, 1'b1);
    end

    // Each op reads the register written just before
    lastD = 4'd1;
    for (int i = 0; i < numChain; i++) begin
      op = pickBasic(4'(randBits(3)));
      d = 4'(randBits(4));
      m = 4'(randBits(4));
      issueOp(op, d, lastD, m, 4'd0, 4'd0, 1'b0, '0, 1'b1);
      lastD = d;
    end

    loadReg(4'd9, 32'd0);
    loadReg(4'd10, 32'd5);
    issueOp(opCbz, 4'd9, 4'd3, 4'd0, 4'd0, 4'd0, 1'b1, randBits(8), 1'b0);
    issueOp(opCbnz, 4'd9, 4'd3, 4'd0, 4'd0, 4'd0, 1'b1, randBits(8), 1'b0);
    issueOp(opCbz, 4'd10, 4'd3, 4'd0, 4'd0, 4'd0, 1'b1, randBits(8), 1'b0);
    issueOp(opCbnz, 4'd10, 4'd3, 4'd0, 4'd0, 4'd0, 1'b1, randBits(8), 1'b0);
    issueOp(opB, 4'd10, 4'd3, 4'd0, 4'd0, 4'd0, 1'b1, randBits(8), 1'b0);

    // Read every register back
    for (int i = 0; i < 16; i++) begin
      issueOp(opMov, 4'(i), 4'd0, 4'(i), 4'd0, 4'd0, 1'b0, '0, 1'b0);
    end

    issue = 1'b0;
    repeat (3) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: execTop.f
source/execPkg.sv
source/alu.sv
source/regFile.sv
source/operandSelect.sv
source/retireStage.sv
source/execTop.sv
sim/clockGen.sv
sim/execTopTb.sv

// File: Bender.yml
package:
  name: exec_top

sources:
  - files:
      - source/execPkg.sv
      - source/alu.sv
      - source/regFile.sv
      - source/operandSelect.sv
      - source/retireStage.sv
      - source/execTop.sv
  - target: test
    files:
      - sim/clockGen.sv
      - sim/execTopTb.sv
